//--- hw/tlb_pkg.sv
// Sizes and entry layout shared by every TLB block
// Page size is fixed at 4 KiB and virtual addresses are 32 bits wide
// Entry layout from the low end is ppn, tag, pid and the valid bit on top
// The sweep period counts cycles of aclk

package tlb_pkg;

  // ----------------------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------------------
  localparam int way_bits = 2;
  localparam int tlb_ways = 1 << way_bits;
  localparam int set_bits = 4;
  localparam int tlb_sets = 1 << set_bits;

  // ----------------------------------------------------------------------
  // Address and entry fields
  // ----------------------------------------------------------------------
  localparam int page_bits  = 12;
  localparam int vaddr_bits = 32;
  localparam int tag_bits   = vaddr_bits - set_bits - page_bits;
  localparam int pid_bits   = 6;
  localparam int ppn_bits   = 20;

  localparam int ppn_lsb    = 0;
  localparam int tag_lsb    = ppn_lsb + ppn_bits;
  localparam int pid_lsb    = tag_lsb + tag_bits;
  localparam int valid_bit  = pid_lsb + pid_bits;
  localparam int entry_bits = valid_bit + 1;

  // ----------------------------------------------------------------------
  // Reference sweep timer
  // ----------------------------------------------------------------------
  localparam int ref_clr_period = 200;
  localparam int ref_cnt_bits   = $clog2(ref_clr_period);

  // Last count value before a sweep starts
  localparam logic [ref_cnt_bits-1:0] ref_cnt_last = ref_cnt_bits'(ref_clr_period - 1);

endpackage

//--- hw/tlb_way_if.sv
// Buses between the ways and their two users
// Each way drives only its own element of the per-way read arrays
// All read data is registered and valid one cycle after the set index

`timescale 1ns/100ps

// Update controller side
interface tlb_upd_if;
  logic [tlb_pkg::set_bits-1:0]                        upd_set;
  logic [tlb_pkg::tlb_ways-1:0]                        upd_we;
  logic [tlb_pkg::entry_bits-1:0]                      upd_wdata;
  logic [tlb_pkg::tlb_ways-1:0]                        upd_clr_bits;
  logic [tlb_pkg::tlb_ways-1:0][tlb_pkg::entry_bits-1:0] upd_rdata;
  logic [tlb_pkg::tlb_ways-1:0]                        upd_ref;
  logic [tlb_pkg::tlb_ways-1:0]                        upd_mod;

  modport ctrl (output upd_set, upd_we, upd_wdata, upd_clr_bits,
                input  upd_rdata, upd_ref, upd_mod);
  modport way  (input  upd_set, upd_we, upd_wdata, upd_clr_bits,
                output upd_rdata, upd_ref, upd_mod);
endinterface

// Lookup pipeline side
interface tlb_lkp_if;
  logic [tlb_pkg::set_bits-1:0]                        lkp_set;
  logic                                                mark_strobe;
  logic [tlb_pkg::set_bits-1:0]                        mark_set;
  logic [tlb_pkg::tlb_ways-1:0]                        mark_way;
  logic                                                mark_wr;
  logic [tlb_pkg::tlb_ways-1:0][tlb_pkg::entry_bits-1:0] lkp_rdata;

  modport pipe (output lkp_set, mark_strobe, mark_set, mark_way, mark_wr,
                input  lkp_rdata);
  modport way  (input  lkp_set, mark_strobe, mark_set, mark_way, mark_wr,
                output lkp_rdata);
endinterface

//--- hw/tlb_way.sv
// One TLB way with 16 entries plus reference and modified bits
// Two synchronous read ports, one for updates and one for lookups
// A read in the same cycle as a write returns the old entry
// Bit priority per set is update clear, then mark, then sweep clear

`timescale 1ns/100ps

module tlb_way #(
  parameter int way_index = 0
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  tlb_upd_if.way                        upd,
  tlb_lkp_if.way                        lkp,
  input  logic                          sweep_valid,
  input  logic [tlb_pkg::set_bits-1:0]  sweep_set
);

  // Entry payload without the valid bit, which lives in vld_q
  logic [tlb_pkg::valid_bit-1:0]  mem [tlb_pkg::tlb_sets];
  logic [tlb_pkg::tlb_sets-1:0]   vld_q;
  logic [tlb_pkg::tlb_sets-1:0]   ref_q;
  logic [tlb_pkg::tlb_sets-1:0]   mod_q;

  logic [tlb_pkg::entry_bits-1:0] upd_rd_q;
  logic [tlb_pkg::entry_bits-1:0] lkp_rd_q;
  logic                           upd_ref_q;
  logic                           upd_mod_q;

  logic wr_en;
  logic clr_en;
  logic mark_en;

  assign wr_en   = upd.upd_we[way_index];
  assign clr_en  = upd.upd_clr_bits[way_index];
  assign mark_en = lkp.mark_strobe && lkp.mark_way[way_index];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[upd.upd_set] <= upd.upd_wdata[tlb_pkg::valid_bit-1:0];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      vld_q <= '0;
    end else if (wr_en) begin
      vld_q[upd.upd_set] <= upd.upd_wdata[tlb_pkg::valid_bit];
    end
  end

  // Later assignments win, so the update clear has the last word
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ref_q <= '0;
      mod_q <= '0;
    end else begin
      if (sweep_valid) begin
        ref_q[sweep_set] <= 1'b0;
      end
      if (mark_en) begin
        ref_q[lkp.mark_set] <= 1'b1;
        if (lkp.mark_wr) begin
          mod_q[lkp.mark_set] <= 1'b1;
        end
      end
      if (clr_en) begin
        ref_q[upd.upd_set] <= 1'b0;
        mod_q[upd.upd_set] <= 1'b0;
      end
    end
  end

  // Registered read ports
  always_ff @(posedge aclk) begin
    upd_rd_q  <= {vld_q[upd.upd_set], mem[upd.upd_set]};
    upd_ref_q <= ref_q[upd.upd_set];
    upd_mod_q <= mod_q[upd.upd_set];
    lkp_rd_q  <= {vld_q[lkp.lkp_set], mem[lkp.lkp_set]};
  end

  assign upd.upd_rdata[way_index] = upd_rd_q;
  assign upd.upd_ref[way_index]   = upd_ref_q;
  assign upd.upd_mod[way_index]   = upd_mod_q;
  assign lkp.lkp_rdata[way_index] = lkp_rd_q;

endmodule

//--- hw/tlb_update_ctrl.sv
// Update controller for inserts and removes
// A command is a single-cycle strobe with no back-pressure
// Strobes arriving while busy are dropped, so keep them 4 cycles apart
// Insert does not check for an existing mapping of the same page

`timescale 1ns/100ps

module tlb_update_ctrl (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            upd_valid,
  input  logic                            upd_insert,
  input  logic [tlb_pkg::vaddr_bits-1:0]  upd_vaddr,
  input  logic [tlb_pkg::pid_bits-1:0]    upd_pid,
  input  logic [tlb_pkg::ppn_bits-1:0]    upd_ppn,
  tlb_upd_if.ctrl                         upd
);

  // One-hot FSM, all bits low means idle
  logic st_read;
  logic st_cmp;
  logic st_commit;
  logic idle;

  logic                           cmd_insert;
  logic [tlb_pkg::set_bits-1:0]   cmd_set;
  logic [tlb_pkg::tag_bits-1:0]   cmd_tag;
  logic [tlb_pkg::pid_bits-1:0]   cmd_pid;
  logic [tlb_pkg::ppn_bits-1:0]   cmd_ppn;
  logic [tlb_pkg::entry_bits-1:0] wdata;

  logic [tlb_pkg::tlb_ways-1:0]   free_oh;
  logic [tlb_pkg::tlb_ways-1:0]   lru_oh;
  logic [tlb_pkg::tlb_ways-1:0]   match_oh;
  logic [tlb_pkg::tlb_ways-1:0]   sel_oh;
  logic [tlb_pkg::tlb_ways-1:0]   we_q;
  logic                           any_free;
  logic [1:0]                     rank;
  logic [1:0]                     rank_min;

  assign idle = !(st_read || st_cmp || st_commit);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      st_read   <= 1'b0;
      st_cmp    <= 1'b0;
      st_commit <= 1'b0;
    end else begin
      st_read   <= idle && upd_valid;
      st_cmp    <= st_read;
      st_commit <= st_cmp;
    end
  end

  // Command capture and address split
  always_ff @(posedge aclk) begin
    if (idle && upd_valid) begin
      cmd_insert <= upd_insert;
      cmd_set    <= upd_vaddr[tlb_pkg::page_bits +: tlb_pkg::set_bits];
      cmd_tag    <= upd_vaddr[tlb_pkg::page_bits + tlb_pkg::set_bits +: tlb_pkg::tag_bits];
      cmd_pid    <= upd_pid;
      cmd_ppn    <= upd_ppn;
    end
  end

  // ----------------------------------------------------------------------
  // Way selection during compare
  // ----------------------------------------------------------------------
  always_comb begin
    free_oh  = '0;
    lru_oh   = '0;
    match_oh = '0;
    any_free = 1'b0;
    rank     = 2'b00;
    rank_min = 2'b11;

    // Scan downward so the lowest free way is kept
    for (int w = tlb_pkg::tlb_ways - 1; w >= 0; w--) begin
      if (!upd.upd_rdata[w][tlb_pkg::valid_bit]) begin
        any_free   = 1'b1;
        free_oh    = '0;
        free_oh[w] = 1'b1;
      end
    end

    // Rank is ref above mod, ties go to the higher way
    for (int w = 0; w < tlb_pkg::tlb_ways; w++) begin
      rank = {upd.upd_ref[w], upd.upd_mod[w]};
      if (rank <= rank_min) begin
        rank_min  = rank;
        lru_oh    = '0;
        lru_oh[w] = 1'b1;
      end
      match_oh[w] = upd.upd_rdata[w][tlb_pkg::valid_bit] &&
                    (upd.upd_rdata[w][tlb_pkg::tag_lsb +: tlb_pkg::tag_bits] == cmd_tag) &&
                    (upd.upd_rdata[w][tlb_pkg::pid_lsb +: tlb_pkg::pid_bits] == cmd_pid);
    end

    if (cmd_insert) begin
      sel_oh = any_free ? free_oh : lru_oh;
    end else begin
      sel_oh = match_oh;
    end
  end

  // Write enables only live during commit
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      we_q <= '0;
    end else begin
      we_q <= st_cmp ? sel_oh : '0;
    end
  end

  // Remove writes the same word with valid low
  always_comb begin
    wdata = '0;
    wdata[tlb_pkg::ppn_lsb +: tlb_pkg::ppn_bits] = cmd_ppn;
    wdata[tlb_pkg::tag_lsb +: tlb_pkg::tag_bits] = cmd_tag;
    wdata[tlb_pkg::pid_lsb +: tlb_pkg::pid_bits] = cmd_pid;
    wdata[tlb_pkg::valid_bit]                    = cmd_insert;
  end

  assign upd.upd_set      = cmd_set;
  assign upd.upd_wdata    = wdata;
  assign upd.upd_we       = we_q;
  assign upd.upd_clr_bits = we_q;

endmodule

//--- hw/tlb_lookup.sv
// Three-stage lookup pipeline, one request per cycle
// lkp_done comes 3 cycles after the sampling edge with hit and ppn
// The reference mark is issued 2 cycles after sampling
// With duplicate mappings the highest matching way wins

`timescale 1ns/100ps

module tlb_lookup (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            lkp_valid,
  input  logic                            lkp_wr,
  input  logic [tlb_pkg::vaddr_bits-1:0]  lkp_vaddr,
  input  logic [tlb_pkg::pid_bits-1:0]    lkp_pid,
  output logic                            lkp_done,
  output logic                            lkp_hit,
  output logic [tlb_pkg::ppn_bits-1:0]    lkp_ppn,
  tlb_lkp_if.pipe                         lkp
);

  logic                          s1_valid;
  logic                          s1_wr;
  logic [tlb_pkg::set_bits-1:0]  s1_set;
  logic [tlb_pkg::tag_bits-1:0]  s1_tag;
  logic [tlb_pkg::pid_bits-1:0]  s1_pid;

  logic                          hit;
  logic [tlb_pkg::tlb_ways-1:0]  hit_oh;
  logic [tlb_pkg::ppn_bits-1:0]  hit_ppn;

  logic                          s2_valid;
  logic                          s2_hit;
  logic [tlb_pkg::ppn_bits-1:0]  s2_ppn;
  logic                          mark_q;
  logic [tlb_pkg::set_bits-1:0]  mark_set_q;
  logic [tlb_pkg::tlb_ways-1:0]  mark_way_q;
  logic                          mark_wr_q;

  // Stage 0 addresses the ways straight from the request
  assign lkp.lkp_set = lkp_vaddr[tlb_pkg::page_bits +: tlb_pkg::set_bits];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= lkp_valid;
    end
  end

  always_ff @(posedge aclk) begin
    s1_wr  <= lkp_wr;
    s1_set <= lkp.lkp_set;
    s1_tag <= lkp_vaddr[tlb_pkg::page_bits + tlb_pkg::set_bits +: tlb_pkg::tag_bits];
    s1_pid <= lkp_pid;
  end

  // Stage 1 tag compare
  always_comb begin
    hit     = 1'b0;
    hit_oh  = '0;
    hit_ppn = '0;
    for (int w = 0; w < tlb_pkg::tlb_ways; w++) begin
      if (s1_valid && lkp.lkp_rdata[w][tlb_pkg::valid_bit] &&
          (lkp.lkp_rdata[w][tlb_pkg::tag_lsb +: tlb_pkg::tag_bits] == s1_tag) &&
          (lkp.lkp_rdata[w][tlb_pkg::pid_lsb +: tlb_pkg::pid_bits] == s1_pid)) begin
        hit       = 1'b1;
        hit_oh    = '0;
        hit_oh[w] = 1'b1;
        hit_ppn   = lkp.lkp_rdata[w][tlb_pkg::ppn_lsb +: tlb_pkg::ppn_bits];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s2_valid <= 1'b0;
      s2_hit   <= 1'b0;
      mark_q   <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_hit   <= hit;
      mark_q   <= hit;
    end
  end

  always_ff @(posedge aclk) begin
    s2_ppn     <= hit_ppn;
    mark_set_q <= s1_set;
    mark_way_q <= hit_oh;
    mark_wr_q  <= s1_wr;
  end

  assign lkp.mark_strobe = mark_q;
  assign lkp.mark_set    = mark_set_q;
  assign lkp.mark_way    = mark_way_q;
  assign lkp.mark_wr     = mark_wr_q;

  // Stage 2 result registers
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lkp_done <= 1'b0;
      lkp_hit  <= 1'b0;
    end else begin
      lkp_done <= s2_valid;
      lkp_hit  <= s2_hit;
    end
  end

  always_ff @(posedge aclk) begin
    lkp_ppn <= s2_ppn;
  end

endmodule

//--- hw/tlb_ref_sweeper.sv
// Periodic reference bit sweep
// Waits ref_clr_period cycles, then walks sets 0 to 15 one per cycle
// The period count restarts once the last set is cleared

`timescale 1ns/100ps

module tlb_ref_sweeper (
  input  logic                          aclk,
  input  logic                          aresetn,
  output logic                          sweep_valid,
  output logic [tlb_pkg::set_bits-1:0]  sweep_set
);

  logic [tlb_pkg::ref_cnt_bits-1:0] period_cnt;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      period_cnt  <= '0;
      sweep_valid <= 1'b0;
      sweep_set   <= '0;
    end else if (sweep_valid) begin
      // Walk the sets
      if (sweep_set == '1) begin
        sweep_valid <= 1'b0;
        sweep_set   <= '0;
      end else begin
        sweep_set <= sweep_set + 1'b1;
      end
    end else if (period_cnt == tlb_pkg::ref_cnt_last) begin
      period_cnt  <= '0;
      sweep_valid <= 1'b1;
      sweep_set   <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

endmodule

//--- hw/tlb_top.sv
// TLB controller top level with 4 ways of 16 sets
// Update and lookup requests are single-cycle strobes without back-pressure
// Update strobes must be at least 4 cycles apart

`timescale 1ns/100ps

module tlb_top (
  input  logic                            aclk,
  input  logic                            aresetn,

  input  logic                            upd_valid,
  input  logic                            upd_insert,
  input  logic [tlb_pkg::vaddr_bits-1:0]  upd_vaddr,
  input  logic [tlb_pkg::pid_bits-1:0]    upd_pid,
  input  logic [tlb_pkg::ppn_bits-1:0]    upd_ppn,

  input  logic                            lkp_valid,
  input  logic                            lkp_wr,
  input  logic [tlb_pkg::vaddr_bits-1:0]  lkp_vaddr,
  input  logic [tlb_pkg::pid_bits-1:0]    lkp_pid,
  output logic                            lkp_done,
  output logic                            lkp_hit,
  output logic [tlb_pkg::ppn_bits-1:0]    lkp_ppn
);

  tlb_upd_if upd_bus ();
  tlb_lkp_if lkp_bus ();

  logic                         sweep_valid;
  logic [tlb_pkg::set_bits-1:0] sweep_set;

  tlb_update_ctrl u_update_ctrl (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .upd_valid  (upd_valid),
    .upd_insert (upd_insert),
    .upd_vaddr  (upd_vaddr),
    .upd_pid    (upd_pid),
    .upd_ppn    (upd_ppn),
    .upd        (upd_bus.ctrl)
  );

  tlb_lookup u_lookup (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .lkp_valid (lkp_valid),
    .lkp_wr    (lkp_wr),
    .lkp_vaddr (lkp_vaddr),
    .lkp_pid   (lkp_pid),
    .lkp_done  (lkp_done),
    .lkp_hit   (lkp_hit),
    .lkp_ppn   (lkp_ppn),
    .lkp       (lkp_bus.pipe)
  );

  tlb_ref_sweeper u_sweeper (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .sweep_valid (sweep_valid),
    .sweep_set   (sweep_set)
  );

  // ----------------------------------------------------------------------
  // Ways
  // ----------------------------------------------------------------------
  for (genvar w = 0; w < tlb_pkg::tlb_ways; w++) begin : g_way
    tlb_way #(
      .way_index (w)
    ) u_way (
      .aclk        (aclk),
      .aresetn     (aresetn),
      .upd         (upd_bus.way),
      .lkp         (lkp_bus.way),
      .sweep_valid (sweep_valid),
      .sweep_set   (sweep_set)
    );
  end

endmodule

//--- verification/tlb_asserts.sv
// Protocol and timing checks bound into tlb_top
// Update strobes must be at least 4 cycles apart
// The lookup latency check assumes lkp_valid is held low during reset

`timescale 1ns/100ps

module tlb_asserts (
  input logic                          aclk,
  input logic                          aresetn,
  input logic                          upd_valid,
  input logic                          lkp_valid,
  input logic                          lkp_done,
  input logic                          lkp_hit,
  input logic                          sweep_valid,
  input logic [tlb_pkg::set_bits-1:0]  sweep_set
);

  // ----------------------------------------------------------------------
  // Command and lookup protocol
  // ----------------------------------------------------------------------
  a_upd_spacing: assert property (@(posedge aclk) disable iff (!aresetn)
    upd_valid |-> !$past(upd_valid, 1) && !$past(upd_valid, 2) && !$past(upd_valid, 3))
    else $error("update strobe arrived less than 4 cycles after the previous one");

  a_lkp_latency: assert property (@(posedge aclk) disable iff (!aresetn)
    lkp_done == $past(lkp_valid, 3))
    else $error("lkp_done does not follow lkp_valid by exactly 3 cycles");

  // First edge after reset release
  a_reset_state: assert property (@(posedge aclk)
    aresetn && $past(!aresetn) |-> !lkp_done && !lkp_hit && !sweep_valid)
    else $error("lookup or sweep outputs not low out of reset");

  // Sweep walks the sets in order
  a_sweep_walk: assert property (@(posedge aclk) disable iff (!aresetn)
    sweep_valid && (sweep_set != '1) |=> sweep_valid && (sweep_set == $past(sweep_set) + 1'b1))
    else $error("sweep stopped or skipped a set");

endmodule

bind tlb_top tlb_asserts u_asserts (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .upd_valid   (upd_valid),
  .lkp_valid   (lkp_valid),
  .lkp_done    (lkp_done),
  .lkp_hit     (lkp_hit),
  .sweep_valid (sweep_valid),
  .sweep_set   (sweep_set)
);

//--- verification/tlb_tb.sv
// Testbench for tlb_top with a behavioral reference model
// Sweep schedule is counted from the first edge after reset release
// Tests that depend on reference bits keep lookups away from sweeps

`timescale 1ns/100ps

module tlb_tb;

  localparam int test_cycles = 1100;
  localparam int ref_period  = 200;
  localparam int sweep_first = ref_period + 1;
  localparam int sweep_cycle = ref_period + 16;

  logic        aclk;
  logic        aresetn;
  logic        upd_valid;
  logic        upd_insert;
  logic [31:0] upd_vaddr;
  logic [5:0]  upd_pid;
  logic [19:0] upd_ppn;
  logic        lkp_valid;
  logic        lkp_wr;
  logic [31:0] lkp_vaddr;
  logic [5:0]  lkp_pid;
  logic        lkp_done;
  logic        lkp_hit;
  logic [19:0] lkp_ppn;

  integer seed;
  string  test_name;
  int     edge_k = 0;
  int     swept_k = 0;
  int     tag_seq = 0;

  // Reference model of the TLB contents
  logic        m_valid [16][4];
  logic [15:0] m_tag   [16][4];
  logic [5:0]  m_pid   [16][4];
  logic [19:0] m_ppn   [16][4];
  logic        m_ref   [16][4];
  logic        m_mod   [16][4];
  logic [15:0] t_tag   [5];

  // Expected results travel alongside the DUT pipeline
  logic [2:0]  exp_done = '0;
  logic [2:0]  exp_hit = '0;
  logic [19:0] exp_ppn [3];
  logic        in_hit;
  logic [19:0] in_ppn;

  tlb_top uut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .upd_valid  (upd_valid),
    .upd_insert (upd_insert),
    .upd_vaddr  (upd_vaddr),
    .upd_pid    (upd_pid),
    .upd_ppn    (upd_ppn),
    .lkp_valid  (lkp_valid),
    .lkp_wr     (lkp_wr),
    .lkp_vaddr  (lkp_vaddr),
    .lkp_pid    (lkp_pid),
    .lkp_done   (lkp_done),
    .lkp_hit    (lkp_hit),
    .lkp_ppn    (lkp_ppn)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    if (aresetn) begin
      edge_k <= edge_k + 1;
    end
    exp_done   <= {exp_done[1:0], lkp_valid};
    exp_hit    <= {exp_hit[1:0], lkp_valid && in_hit};
    exp_ppn[0] <= in_ppn;
    exp_ppn[1] <= exp_ppn[0];
    exp_ppn[2] <= exp_ppn[1];
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] expv,
                                 input logic [31:0] actv);
    $display("Mismatch in %s (%s): expected %0h, actual %0h", test_name, what, expv, actv);
    $display("Something failed");
    $fatal(1, "lookup check failed");
  endtask

  c_done: assert property (@(posedge aclk) disable iff (!aresetn) lkp_done == exp_done[2])
    else report_mismatch("lkp_done", $sampled(exp_done[2]), $sampled(lkp_done));

  c_hit: assert property (@(posedge aclk) disable iff (!aresetn)
    lkp_done |-> lkp_hit == exp_hit[2])
    else report_mismatch("lkp_hit", $sampled(exp_hit[2]), $sampled(lkp_hit));

  c_ppn: assert property (@(posedge aclk) disable iff (!aresetn)
    lkp_done && lkp_hit |-> lkp_ppn == exp_ppn[2])
    else report_mismatch("lkp_ppn", $sampled(exp_ppn[2]), $sampled(lkp_ppn));

  initial begin
    #((test_cycles + 500) * 40ns);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------------------------------------
  // Model helpers
  // ----------------------------------------------------------------------
  task automatic apply_sweeps();
    int s;
    while (swept_k < edge_k) begin
      swept_k++;
      if (swept_k >= sweep_first) begin
        s = (swept_k - sweep_first) % sweep_cycle;
        if (s < 16) begin
          for (int w = 0; w < 4; w++) m_ref[s][w] = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_after_sweep();
    while (!(edge_k > sweep_first && (edge_k - sweep_first) % sweep_cycle == 16)) begin
      @(negedge aclk);
    end
  endtask

  task automatic do_update(input logic insert, input logic [3:0] idx,
                           input logic [15:0] tag, input logic [5:0] pid,
                           input logic [19:0] ppn);
    int          victim;
    logic [1:0]  best;
    logic [31:0] r;
    apply_sweeps();
    victim = -1;
    if (insert) begin
      for (int w = 0; w < 4; w++) begin
        if (!m_valid[idx][w] && victim < 0) victim = w;
      end
      if (victim < 0) begin
        best = 2'b11;
        for (int w = 0; w < 4; w++) begin
          if ({m_ref[idx][w], m_mod[idx][w]} <= best) begin
            best   = {m_ref[idx][w], m_mod[idx][w]};
            victim = w;
          end
        end
      end
      m_valid[idx][victim] = 1'b1;
      m_tag[idx][victim]   = tag;
      m_pid[idx][victim]   = pid;
      m_ppn[idx][victim]   = ppn;
      m_ref[idx][victim]   = 1'b0;
      m_mod[idx][victim]   = 1'b0;
    end else begin
      for (int w = 0; w < 4; w++) begin
        if (m_valid[idx][w] && m_tag[idx][w] == tag && m_pid[idx][w] == pid) begin
          m_valid[idx][w] = 1'b0;
          m_ref[idx][w]   = 1'b0;
          m_mod[idx][w]   = 1'b0;
        end
      end
    end
    r = $random(seed);
    @(negedge aclk);
    upd_valid  = 1'b1;
    upd_insert = insert;
    upd_vaddr  = {tag, idx, r[11:0]};
    upd_pid    = pid;
    upd_ppn    = ppn;
    @(negedge aclk);
    upd_valid = 1'b0;
    repeat (4) @(negedge aclk);
  endtask

  // Inserts a fresh random mapping and remembers its tag in slot k
  task automatic insert_new(input logic [3:0] idx, input int k, input logic [5:0] pid);
    logic [31:0] r;
    logic [31:0] p;
    r = $random(seed);
    p = $random(seed);
    t_tag[k] = {r[11:0], tag_seq[3:0]};
    tag_seq++;
    do_update(1'b1, idx, t_tag[k], pid, p[19:0]);
  endtask

  task automatic issue_lookup(input logic [3:0] idx, input logic [15:0] tag,
                              input logic [5:0] pid, input logic wr);
    logic [31:0] r;
    apply_sweeps();
    r = $random(seed);
    @(negedge aclk);
    in_hit = 1'b0;
    in_ppn = '0;
    for (int w = 0; w < 4; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag && m_pid[idx][w] == pid) begin
        in_hit = 1'b1;
        in_ppn = m_ppn[idx][w];
        m_ref[idx][w] = 1'b1;
        if (wr) m_mod[idx][w] = 1'b1;
      end
    end
    lkp_valid = 1'b1;
    lkp_wr    = wr;
    lkp_vaddr = {tag, idx, r[11:0]};
    lkp_pid   = pid;
  endtask

  task automatic finish_lookups();
    @(negedge aclk);
    lkp_valid = 1'b0;
    in_hit    = 1'b0;
    repeat (5) @(negedge aclk);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    seed       = 32'h2d5b;
    test_name  = "reset";
    aresetn    = 1'b0;
    upd_valid  = 1'b0;
    upd_insert = 1'b0;
    upd_vaddr  = '0;
    upd_pid    = '0;
    upd_ppn    = '0;
    lkp_valid  = 1'b0;
    lkp_wr     = 1'b0;
    lkp_vaddr  = '0;
    lkp_pid    = '0;
    in_hit     = 1'b0;
    in_ppn     = '0;
    for (int s = 0; s < 16; s++) begin
      for (int w = 0; w < 4; w++) begin
        m_valid[s][w] = 1'b0;
        m_ref[s][w]   = 1'b0;
        m_mod[s][w]   = 1'b0;
      end
    end
    repeat (10) @(negedge aclk);
    aresetn = 1'b1;
    repeat (2) @(negedge aclk);

    test_name = "insert_hit";
    insert_new(4'd1, 0, 6'd5);
    issue_lookup(4'd1, t_tag[0], 6'd5, 1'b0);
    finish_lookups();

    test_name = "miss";
    issue_lookup(4'd1, t_tag[0] ^ 16'h8000, 6'd5, 1'b0);
    issue_lookup(4'd1, t_tag[0], 6'd6, 1'b0);
    finish_lookups();

    test_name = "remove";
    insert_new(4'd3, 0, 6'd7);
    insert_new(4'd3, 1, 6'd7);
    do_update(1'b0, 4'd3, t_tag[0], 6'd7, '0);
    issue_lookup(4'd3, t_tag[0], 6'd7, 1'b0);
    issue_lookup(4'd3, t_tag[1], 6'd7, 1'b0);
    finish_lookups();

    test_name = "back_to_back";
    insert_new(4'd6, 0, 6'd2);
    insert_new(4'd6, 1, 6'd2);
    issue_lookup(4'd6, t_tag[0], 6'd2, 1'b0);
    issue_lookup(4'd6, t_tag[1], 6'd2, 1'b1);
    issue_lookup(4'd6, t_tag[1] ^ 16'h4000, 6'd2, 1'b0);
    issue_lookup(4'd6, t_tag[0], 6'd2, 1'b0);
    finish_lookups();

    test_name = "replace_unused";
    wait_after_sweep();
    for (int k = 0; k < 4; k++) insert_new(4'd4, k, 6'd9);
    issue_lookup(4'd4, t_tag[0], 6'd9, 1'b0);
    issue_lookup(4'd4, t_tag[1], 6'd9, 1'b0);
    issue_lookup(4'd4, t_tag[3], 6'd9, 1'b0);
    finish_lookups();
    insert_new(4'd4, 4, 6'd9);
    for (int k = 0; k < 5; k++) issue_lookup(4'd4, t_tag[k], 6'd9, 1'b0);
    finish_lookups();

    test_name = "replace_rank";
    for (int k = 0; k < 4; k++) insert_new(4'd5, k, 6'd12);
    for (int k = 0; k < 4; k++) issue_lookup(4'd5, t_tag[k], 6'd12, k == 3);
    finish_lookups();
    wait_after_sweep();
    insert_new(4'd5, 4, 6'd12);
    for (int k = 0; k < 5; k++) issue_lookup(4'd5, t_tag[k], 6'd12, 1'b0);
    finish_lookups();

    $display("Everything OK");
    $finish;
  end

endmodule

//--- tlb_ctrl.f
hw/tlb_pkg.sv
hw/tlb_way_if.sv
hw/tlb_way.sv
hw/tlb_update_ctrl.sv
hw/tlb_lookup.sv
hw/tlb_ref_sweeper.sv
hw/tlb_top.sv
verification/tlb_asserts.sv
verification/tlb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tlb_ctrl.f --top-module tlb_tb -o tlb_sim

out=$(./obj_dir/tlb_sim || true)
echo "$out"

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
else
  exit 1
fi
